/* bp_cfg_pkg.sv */
package bp_cfg_pkg;

  // Fetch and branch target address width.
  localparam int unsigned XLEN = 32;

  // Default BTB index width for a 64-entry table.
  localparam int unsigned BTB_INDEX_W_DEF = 6;

  // Default BHT index width for a 128-counter table.
  localparam int unsigned BHT_INDEX_W_DEF = 7;

endpackage

/* bp_types_pkg.sv */
package bp_types_pkg;

  import bp_cfg_pkg::*;

  // Control-flow class of an instruction.
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_COND = 3'd1,
    BR_JUMP = 3'd2,
    BR_CALL = 3'd3,
    BR_RET  = 3'd4
  } branch_type_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
  } bp_req_t;

  // Committed control-flow instruction from the commit stage.
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] npc;
    branch_type_e    branch_type;
    logic            partial;
    logic            taken;
  } bp_train_t;

  typedef struct packed {
    logic            hit;
    branch_type_e    branch_type;
    logic            partial;
    logic [XLEN-1:0] target;
  } btb_lookup_t;

  typedef struct packed {
    logic [XLEN-1:0] pc_next;
    logic            taken;
    branch_type_e    branch_type;
    logic            partial;
  } bp_pred_t;

endpackage

/* branch_target_buffer.sv */
`timescale 1ns/10ps

module branch_target_buffer #(
  parameter int unsigned BtbIndexWidth = bp_cfg_pkg::BTB_INDEX_W_DEF
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        train_valid_i,
  input  bp_types_pkg::bp_train_t     train_i,
  input  logic                        lookup_en_i,
  input  logic [bp_cfg_pkg::XLEN-1:0] lookup_pc_i,
  output bp_types_pkg::btb_lookup_t   lookup_o
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  localparam int unsigned Entries  = 2 ** BtbIndexWidth;
  localparam int unsigned TagWidth = XLEN - BtbIndexWidth - 2;

  // Target bit 0 is always zero, so it is not stored.
  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic                partial;
    logic [XLEN-1:1]     target;
    branch_type_e        branch_type;
  } btb_entry_t;

  btb_entry_t         mem_q [Entries];
  logic [Entries-1:0] valid_q;

  logic [BtbIndexWidth-1:0] train_idx;
  logic [TagWidth-1:0]      train_tag;
  logic                     train_we;
  logic [BtbIndexWidth-1:0] lookup_idx;
  logic [TagWidth-1:0]      lookup_tag;

  btb_entry_t          entry_q;
  logic [TagWidth-1:0] tag_q;
  logic                entry_valid_q;

  assign train_idx  = train_i.pc[2 +: BtbIndexWidth];
  assign train_tag  = train_i.pc[2 + BtbIndexWidth +: TagWidth];
  assign train_we   = train_valid_i && train_i.taken;
  assign lookup_idx = lookup_pc_i[2 +: BtbIndexWidth];
  assign lookup_tag = lookup_pc_i[2 + BtbIndexWidth +: TagWidth];

  always_ff @(posedge clk_i) begin
    if (train_we) begin
      mem_q[train_idx] <= '{
        tag:         train_tag,
        partial:     train_i.partial,
        target:      train_i.npc[XLEN-1:1],
        branch_type: train_i.branch_type
      };
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (train_we) begin
      valid_q[train_idx] <= 1'b1;
    end
  end

  // A lookup on the same edge as a training write reads the old entry.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_valid_q <= 1'b0;
    end else if (lookup_en_i) begin
      entry_valid_q <= valid_q[lookup_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      entry_q <= mem_q[lookup_idx];
      tag_q   <= lookup_tag;
    end
  end

  always_comb begin
    lookup_o.hit         = entry_valid_q && (entry_q.tag == tag_q);
    lookup_o.branch_type = entry_q.branch_type;
    lookup_o.partial     = entry_q.partial;
    lookup_o.target      = {entry_q.target, 1'b0};
  end

endmodule

/* branch_history_table.sv */
`timescale 1ns/10ps

module branch_history_table #(
  parameter int unsigned BhtIndexWidth = bp_cfg_pkg::BHT_INDEX_W_DEF
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        train_valid_i,
  input  bp_types_pkg::bp_train_t     train_i,
  input  logic                        lookup_en_i,
  input  logic [bp_cfg_pkg::XLEN-1:0] lookup_pc_i,
  output logic [1:0]                  counter_o
);

  import bp_types_pkg::*;

  localparam int unsigned Entries = 2 ** BhtIndexWidth;

  // Weakly not taken.
  localparam logic [1:0] CntInit = 2'b01;

  logic [1:0] cnt_q [Entries];
  logic [1:0] counter_q;

  logic [BhtIndexWidth-1:0] train_idx;
  logic [BhtIndexWidth-1:0] lookup_idx;
  logic                     train_upd;
  logic [1:0]               cnt_cur;
  logic [1:0]               cnt_next;

  assign train_idx  = train_i.pc[2 +: BhtIndexWidth];
  assign lookup_idx = lookup_pc_i[2 +: BhtIndexWidth];
  assign train_upd  = train_valid_i && (train_i.branch_type == BR_COND);
  assign cnt_cur    = cnt_q[train_idx];

  // Saturating step toward the committed outcome.
  always_comb begin
    cnt_next = cnt_cur;
    if (train_i.taken) begin
      if (cnt_cur != 2'b11) cnt_next = cnt_cur + 2'b01;
    end else begin
      if (cnt_cur != 2'b00) cnt_next = cnt_cur - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Entries; i++) begin
        cnt_q[i] <= CntInit;
      end
    end else if (train_upd) begin
      cnt_q[train_idx] <= cnt_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      counter_q <= CntInit;
    end else if (lookup_en_i) begin
      counter_q <= cnt_q[lookup_idx];
    end
  end

  assign counter_o = counter_q;

endmodule

/* next_pc_select.sv */
`timescale 1ns/10ps

module next_pc_select (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  bp_types_pkg::bp_req_t       req_i,
  input  logic                        resp_ready_i,
  input  bp_types_pkg::btb_lookup_t   btb_i,
  input  logic [1:0]                  counter_i,
  output logic                        req_ready_o,
  output logic                        lookup_en_o,
  output logic [bp_cfg_pkg::XLEN-1:0] lookup_pc_o,
  output logic                        resp_valid_o,
  output bp_types_pkg::bp_pred_t      resp_o
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  logic            resp_valid_q;
  logic [XLEN-1:0] pc_q;
  logic            req_fire;
  logic            pred_taken;

  // A held response that is leaving frees the slot in the same cycle.
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign lookup_en_o = req_fire;
  assign lookup_pc_o = req_i.pc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      pc_q <= req_i.pc;
    end
  end

  // Unconditional types are always taken on a hit. Branches need a counter of 2 or 3.
  assign pred_taken = btb_i.hit && ((btb_i.branch_type != BR_COND) || counter_i[1]);

  always_comb begin
    resp_o.taken       = pred_taken;
    resp_o.pc_next     = pred_taken ? btb_i.target : pc_q + XLEN'(4);
    resp_o.branch_type = btb_i.hit ? btb_i.branch_type : BR_NONE;
    resp_o.partial     = btb_i.hit && btb_i.partial;
  end

  assign resp_valid_o = resp_valid_q;

endmodule

/* branch_predictor.sv */
`timescale 1ns/10ps

module branch_predictor #(
  parameter int unsigned BtbIndexWidth = bp_cfg_pkg::BTB_INDEX_W_DEF,
  parameter int unsigned BhtIndexWidth = bp_cfg_pkg::BHT_INDEX_W_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  bp_types_pkg::bp_req_t   req_i,

  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output bp_types_pkg::bp_pred_t  resp_o,

  input  logic                    train_valid_i,
  input  bp_types_pkg::bp_train_t train_i
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  logic            lookup_en;
  logic [XLEN-1:0] lookup_pc;
  btb_lookup_t     btb_lookup;
  logic [1:0]      bht_counter;

  branch_target_buffer #(
    .BtbIndexWidth (BtbIndexWidth)
  ) u_btb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .train_valid_i (train_valid_i),
    .train_i       (train_i),
    .lookup_en_i   (lookup_en),
    .lookup_pc_i   (lookup_pc),
    .lookup_o      (btb_lookup)
  );

  branch_history_table #(
    .BhtIndexWidth (BhtIndexWidth)
  ) u_bht (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .train_valid_i (train_valid_i),
    .train_i       (train_i),
    .lookup_en_i   (lookup_en),
    .lookup_pc_i   (lookup_pc),
    .counter_o     (bht_counter)
  );

  next_pc_select u_sel (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .resp_ready_i (resp_ready_i),
    .btb_i        (btb_lookup),
    .counter_i    (bht_counter),
    .req_ready_o  (req_ready_o),
    .lookup_en_o  (lookup_en),
    .lookup_pc_o  (lookup_pc),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

/* branch_predictor_assert.sv */
`timescale 1ns/10ps

module branch_predictor_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_ready_i,
  input logic                   resp_valid_i,
  input logic                   resp_ready_i,
  input bp_types_pkg::bp_pred_t resp_i
);

  // Slot is empty in reset and on the first edge out of it.
  reset_empty_a: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> !resp_valid_i)
    else $error("response valid in or right after reset");

  // A stalled response keeps its payload.
  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_i)))
    else $error("stalled response changed or dropped");

  // Empty slot always takes a request.
  ready_when_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !resp_valid_i |-> req_ready_i)
    else $error("request not ready while no response is held");

endmodule

bind branch_predictor branch_predictor_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_i       (resp_o)
);

/* tb_branch_predictor.sv */
`timescale 1ns/10ps

module tb_branch_predictor;

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  localparam int MaxRecords = 128;
  localparam logic [3:0] KindTrain = 4'h1;
  localparam logic [3:0] KindLookup = 4'h2;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  bp_req_t   req_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  bp_pred_t  resp_o;
  logic      train_valid_i;
  bp_train_t train_i;

  // Record is kind, test, pc, npc, type, partial, taken (84 bits).
  logic [83:0] stim_mem [MaxRecords];
  int          n_records;
  int          cycle_limit;
  int          cycle_cnt;
  int          errors;
  int          checks;
  logic [31:0] lfsr;
  int          exp_q [$];

  branch_predictor #(
    .BtbIndexWidth (BTB_INDEX_W_DEF),
    .BhtIndexWidth (BHT_INDEX_W_DEF)
  ) dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_o        (resp_o),
    .train_valid_i (train_valid_i),
    .train_i       (train_i)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ LfsrTaps;
    return b;
  endfunction

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1: return "reset_miss";
      4'd2: return "uncond_hit";
      4'd3: return "cond_counter";
      4'd4: return "alias";
      4'd5: return "backpressure_stream";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_response(input int idx);
    logic [83:0] rec;
    string       name;
    rec  = stim_mem[idx];
    name = $sformatf("%s rec %0d", test_name(rec[79:76]), idx);
    check_value({name, " pc_next"}, rec[43:12], resp_o.pc_next);
    check_value({name, " taken"}, {31'd0, rec[0]}, {31'd0, resp_o.taken});
    check_value({name, " type"}, {29'd0, rec[10:8]}, {29'd0, resp_o.branch_type});
    check_value({name, " partial"}, {31'd0, rec[4]}, {31'd0, resp_o.partial});
  endtask

  task automatic drive_train(input logic [83:0] rec);
    train_i.pc          = rec[75:44];
    train_i.npc         = rec[43:12];
    train_i.branch_type = branch_type_e'(rec[10:8]);
    train_i.partial     = rec[4];
    train_i.taken       = rec[0];
    train_valid_i       = 1'b1;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int          rec_idx;
    int          pending_idx;
    logic        req_pending;
    logic [83:0] rec;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    resp_ready_i  = 1'b0;
    train_valid_i = 1'b0;
    train_i       = '0;
    errors        = 0;
    checks        = 0;
    cycle_cnt     = 0;
    lfsr          = 32'h92d04ad1;
    for (int i = 0; i < MaxRecords; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("bp_stim.txt", stim_mem);
    n_records = 0;
    while (n_records < MaxRecords && stim_mem[n_records][83:80] != 4'h0) begin
      n_records++;
    end
    cycle_limit = 20 * n_records + 100;
    if (n_records == 0) begin
      errors++;
      $display("The stimulus file bp_stim.txt holds no records");
    end

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    rec_idx     = 0;
    pending_idx = 0;
    req_pending = 1'b0;
    while (rec_idx < n_records || req_pending || exp_q.size() > 0) begin
      @(negedge clk_i);
      train_valid_i = 1'b0;
      if (!req_pending) req_valid_i = 1'b0;

      // Response side with random back-pressure.
      resp_ready_i = !rand_bit();
      if (resp_valid_o && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("A response arrived with no request outstanding");
        end else begin
          check_response(exp_q.pop_front());
        end
      end

      // Training only happens while no request waits.
      if (!req_pending && rec_idx < n_records) begin
        rec = stim_mem[rec_idx];
        if (rec[83:80] == KindTrain) begin
          drive_train(rec);
          rec_idx++;
        end else if (rec[83:80] == KindLookup) begin
          if (!rand_bit()) begin
            req_i.pc    = rec[75:44];
            req_valid_i = 1'b1;
            req_pending = 1'b1;
            pending_idx = rec_idx;
            rec_idx++;
          end
        end else begin
          errors++;
          $display("Record %0d has an unknown kind %h", rec_idx, rec[83:80]);
          rec_idx++;
        end
      end

      #1;
      if (req_pending && req_ready_o) begin
        exp_q.push_back(pending_idx);
        req_pending = 1'b0;
      end
    end

    // No further response may show up.
    resp_ready_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      train_valid_i = 1'b0;
      req_valid_i   = 1'b0;
      if (resp_valid_o) begin
        errors++;
        $display("An extra response appeared after all requests were answered");
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* bp_stim.txt */
// Fields in hex are kind, test, pc, npc, type, partial and taken.
// Kind 1 is a training record. Kind 2 is a lookup whose npc is the expected pc_next.
2_1_00001000_00001004_0_0_0
2_1_00002044_00002048_0_0_0
2_1_fffffffc_00000000_0_0_0
2_1_00000010_00000014_0_0_0
1_2_00001000_00003000_2_0_1
2_2_00001000_00003000_2_0_1
1_2_00001104_00004aa2_3_1_1
2_2_00001104_00004aa2_3_1_1
1_2_00001208_00001100_4_0_1
2_2_00001208_00001100_4_0_1
1_2_0000130c_00005000_2_0_0
2_2_0000130c_00001310_0_0_0
2_2_00001000_00003000_2_0_1
2_3_00002010_00002014_0_0_0
1_3_00002010_00002100_1_0_1
2_3_00002010_00002100_1_0_1
1_3_00002010_00002014_1_0_0
2_3_00002010_00002014_1_0_0
1_3_00002010_00002014_1_0_0
2_3_00002010_00002014_1_0_0
1_3_00002010_00002014_1_0_0
1_3_00002010_00002100_1_0_1
1_3_00002010_00002100_1_0_1
2_3_00002010_00002100_1_0_1
1_3_00002010_00002100_1_0_1
1_3_00002010_00002100_1_0_1
1_3_00002010_00002014_1_0_0
1_3_00002010_00002014_1_0_0
2_3_00002010_00002014_1_0_0
1_3_00002324_00002400_1_1_1
2_3_00002324_00002400_1_1_1
2_4_00005000_00005004_0_0_0
2_4_00001000_00003000_2_0_1
1_4_00005000_00006000_3_1_1
2_4_00005000_00006000_3_1_1
2_4_00001000_00001004_0_0_0
2_4_00001104_00004aa2_3_1_1
2_5_00001104_00004aa2_3_1_1
2_5_00001208_00001100_4_0_1
2_5_00005000_00006000_3_1_1
2_5_00002010_00002014_1_0_0
2_5_00003000_00003004_0_0_0
2_5_00001208_00001100_4_0_1
2_5_00002324_00002400_1_1_1
2_5_00000ffc_00001000_0_0_0
2_5_00001100_00001104_0_0_0
2_5_00005000_00006000_3_1_1
2_5_fffffffc_00000000_0_0_0

/* compile.f */
bp_cfg_pkg.sv
bp_types_pkg.sv
branch_target_buffer.sv
branch_history_table.sv
next_pc_select.sv
branch_predictor.sv
branch_predictor_assert.sv
tb_branch_predictor.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vtb_branch_predictor: compile.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module tb_branch_predictor -f compile.f

run: obj_dir/Vtb_branch_predictor bp_stim.txt
	@out="$$(./obj_dir/Vtb_branch_predictor)"; echo "$$out"; \
	  echo "$$out" | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir
